// ==== hw/minisoc_pkg.sv ====
// Mini SoC shared definitions
// Word and index types, RV32I opcodes and branch codes, memory sizes
// and the initial contents of the data memory used by the sort program
package minisoc_pkg;

  localparam int WORD_WIDTH = 32;

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [WORD_WIDTH-1:0] addr_t;
  typedef logic [4:0]            reg_idx_t;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  // Instruction memory depth in words
  localparam int unsigned N_OF_INSTR = 64;

  localparam addr_t       DMEM_START_ADDR = 32'h0000_0400;
  localparam int unsigned DMEM_WORDS      = 16;

  // Word 0 holds the array length in bytes, then eight signed values
  localparam word_t DMEM_INIT [DMEM_WORDS] = '{
    32'd32,
    32'd17, -32'sd4, 32'd9, 32'd0, -32'sd21, 32'd3, 32'd12, -32'sd1,
    32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0
  };

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_COMP    = 7'b0110011;
  localparam logic [6:0] OPCODE_COMPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LOAD    = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE   = 7'b0100011;
  localparam logic [6:0] OPCODE_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL     = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR    = 7'b1100111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

endpackage

// ==== hw/instr_mem.sv ====
// Instruction memory model
// Grant follows the request in the same cycle, the word comes back one
// cycle later with rvalid. The program is built at elaboration from
// encoder functions, selected by PROG_SEL (1 counter, 2 bubble sort)
`timescale 1ns/100ps

module instr_mem #(
  parameter int PROG_SEL = 1
) (
  input  logic               clk,
  input  logic               instr_req_i,
  input  minisoc_pkg::addr_t instr_addr_i,
  output logic               instr_gnt_o,
  output logic               instr_rvalid_o,
  output minisoc_pkg::word_t instr_rdata_o
);

  minisoc_pkg::word_t mem [minisoc_pkg::N_OF_INSTR];
  minisoc_pkg::addr_t word_addr;

  // Low two bits dropped, no misalignment check
  assign word_addr   = instr_addr_i >> 2;
  assign instr_gnt_o = instr_req_i;

  always_ff @(posedge clk) begin
    instr_rvalid_o <= instr_req_i && (word_addr < minisoc_pkg::N_OF_INSTR);
    instr_rdata_o  <= mem[word_addr[$clog2(minisoc_pkg::N_OF_INSTR)-1:0]];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Program loader
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [4:0] X_ZERO = 5'd0;
  localparam logic [4:0] X_RA   = 5'd1;
  localparam logic [4:0] X_T0   = 5'd5;
  localparam logic [4:0] X_T1   = 5'd6;
  localparam logic [4:0] X_T2   = 5'd7;
  localparam logic [4:0] X_S0   = 5'd8;
  localparam logic [4:0] X_S1   = 5'd9;
  localparam logic [4:0] X_S2   = 5'd18;
  localparam logic [4:0] X_S3   = 5'd19;
  localparam logic [4:0] X_S4   = 5'd20;

  function automatic minisoc_pkg::word_t enc_add(logic [4:0] rd, logic [4:0] rs1,
                                                 logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, minisoc_pkg::OPCODE_COMP};
  endfunction

  function automatic minisoc_pkg::word_t enc_addi(logic [4:0] rd, logic [4:0] rs1, int imm);
    return {imm[11:0], rs1, 3'b000, rd, minisoc_pkg::OPCODE_COMPIMM};
  endfunction

  function automatic minisoc_pkg::word_t enc_lw(logic [4:0] rd, logic [4:0] rs1, int imm);
    return {imm[11:0], rs1, 3'b010, rd, minisoc_pkg::OPCODE_LOAD};
  endfunction

  function automatic minisoc_pkg::word_t enc_sw(logic [4:0] rs2, logic [4:0] rs1, int imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], minisoc_pkg::OPCODE_STORE};
  endfunction

  // Shared B-type layout for the four branches
  function automatic minisoc_pkg::word_t enc_br(logic [2:0] f3, logic [4:0] rs1,
                                                logic [4:0] rs2, int imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
            minisoc_pkg::OPCODE_BRANCH};
  endfunction

  function automatic minisoc_pkg::word_t enc_beq(logic [4:0] rs1, logic [4:0] rs2, int imm);
    return enc_br(minisoc_pkg::F3_BEQ, rs1, rs2, imm);
  endfunction

  function automatic minisoc_pkg::word_t enc_bne(logic [4:0] rs1, logic [4:0] rs2, int imm);
    return enc_br(minisoc_pkg::F3_BNE, rs1, rs2, imm);
  endfunction

  function automatic minisoc_pkg::word_t enc_blt(logic [4:0] rs1, logic [4:0] rs2, int imm);
    return enc_br(minisoc_pkg::F3_BLT, rs1, rs2, imm);
  endfunction

  function automatic minisoc_pkg::word_t enc_bge(logic [4:0] rs1, logic [4:0] rs2, int imm);
    return enc_br(minisoc_pkg::F3_BGE, rs1, rs2, imm);
  endfunction

  function automatic minisoc_pkg::word_t enc_jal(logic [4:0] rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, minisoc_pkg::OPCODE_JAL};
  endfunction

  function automatic minisoc_pkg::word_t enc_jalr(logic [4:0] rd, logic [4:0] rs1, int imm);
    return {imm[11:0], rs1, 3'b000, rd, minisoc_pkg::OPCODE_JALR};
  endfunction

  initial begin
    for (int i = 0; i < minisoc_pkg::N_OF_INSTR; i++) begin
      mem[i] = '0;
    end
    case (PROG_SEL)
      1: begin
        // Counter 0..15..0 in s0, s1 is the direction flag, t0 holds 15
        mem[0]  = enc_add(X_S0, X_ZERO, X_ZERO);
        mem[1]  = enc_add(X_S1, X_ZERO, X_ZERO);
        mem[2]  = enc_addi(X_T0, X_ZERO, 15);
        // Loop head at 0x0c
        mem[3]  = enc_beq(X_S1, X_ZERO, 12);
        mem[4]  = enc_addi(X_S0, X_S0, -1);
        mem[5]  = enc_jal(X_ZERO, 8);
        mem[6]  = enc_addi(X_S0, X_S0, 1);
        mem[7]  = enc_bne(X_S0, X_ZERO, 8);
        mem[8]  = enc_add(X_S1, X_ZERO, X_ZERO);
        mem[9]  = enc_bne(X_S0, X_T0, 8);
        mem[10] = enc_addi(X_S1, X_ZERO, 1);
        mem[11] = enc_jal(X_ZERO, -32);
      end
      2: begin
        // s1 array base, s2 length in bytes, s3 outer bound, s4 inner pointer
        mem[0]  = enc_addi(X_S1, X_ZERO, int'(minisoc_pkg::DMEM_START_ADDR));
        mem[1]  = enc_lw(X_S2, X_S1, 0);
        mem[2]  = enc_addi(X_S1, X_S1, 4);
        mem[3]  = enc_jal(X_RA, 8);
        // Self-loop at 0x10 once sorted
        mem[4]  = enc_jal(X_ZERO, 0);
        mem[5]  = enc_add(X_S3, X_S1, X_S2);
        mem[6]  = enc_addi(X_S3, X_S3, -4);
        mem[7]  = enc_add(X_S4, X_S1, X_ZERO);
        // Inner loop at 0x20
        mem[8]  = enc_lw(X_T1, X_S4, 0);
        mem[9]  = enc_lw(X_T2, X_S4, 4);
        mem[10] = enc_bge(X_T2, X_T1, 12);
        mem[11] = enc_sw(X_T1, X_S4, 4);
        mem[12] = enc_sw(X_T2, X_S4, 0);
        mem[13] = enc_addi(X_S4, X_S4, 4);
        mem[14] = enc_blt(X_S4, X_S3, -24);
        mem[15] = enc_addi(X_S3, X_S3, -4);
        mem[16] = enc_bne(X_S3, X_S1, -36);
        mem[17] = enc_jalr(X_ZERO, X_RA, 0);
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/fetch_stage.sv ====
// Fetch stage
// Issues one instruction request per cycle, pairs each returning word
// with the PC it was requested from and drops the wrong-path word that
// is still in flight when execute redirects
`timescale 1ns/100ps

module fetch_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  output logic               instr_req_o,
  output minisoc_pkg::addr_t instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  minisoc_pkg::word_t instr_rdata_i,
  input  logic               redirect_i,
  input  minisoc_pkg::addr_t redirect_pc_i,
  output logic               if_valid_o,
  output minisoc_pkg::addr_t if_pc_o,
  output minisoc_pkg::word_t if_instr_o
);

  logic               run_q;
  logic               stale_q;
  minisoc_pkg::addr_t pc_q;
  minisoc_pkg::addr_t inflight_pc_q;

  // No requests past the end of the program store
  assign instr_req_o  = run_q && (pc_q[31:2] < minisoc_pkg::N_OF_INSTR);
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      run_q   <= 1'b0;
      stale_q <= 1'b0;
      pc_q    <= '0;
    end else begin
      run_q   <= 1'b1;
      // The request issued alongside a redirect is on the wrong path
      stale_q <= redirect_i;
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (instr_req_o && instr_gnt_i) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_req_o && instr_gnt_i) begin
      inflight_pc_q <= pc_q;
    end
  end

  assign if_valid_o = instr_rvalid_i && !stale_q;
  assign if_pc_o    = inflight_pc_q;
  assign if_instr_o = instr_rdata_i;

endmodule

// ==== hw/decode_stage.sv ====
// Decode stage
// Splits the fetched word into fields, builds the sign-extended
// immediate for its format and registers operands for execute
`timescale 1ns/100ps

module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  if_valid_i,
  input  minisoc_pkg::addr_t    if_pc_i,
  input  minisoc_pkg::word_t    if_instr_i,
  input  logic                  flush_i,
  output minisoc_pkg::reg_idx_t rs1_idx_o,
  output minisoc_pkg::reg_idx_t rs2_idx_o,
  input  minisoc_pkg::word_t    rs1_val_i,
  input  minisoc_pkg::word_t    rs2_val_i,
  output logic                  id_valid_o,
  output minisoc_pkg::addr_t    id_pc_o,
  output logic [6:0]            id_opcode_o,
  output logic [2:0]            id_funct3_o,
  output minisoc_pkg::reg_idx_t id_rd_o,
  output minisoc_pkg::word_t    id_rs1_val_o,
  output minisoc_pkg::word_t    id_rs2_val_o,
  output minisoc_pkg::word_t    id_imm_o
);

  logic [6:0]         opcode;
  minisoc_pkg::word_t imm;

  assign opcode    = if_instr_i[6:0];
  assign rs1_idx_o = if_instr_i[19:15];
  assign rs2_idx_o = if_instr_i[24:20];

  // Immediate format follows the opcode, I-type otherwise
  always_comb begin
    case (opcode)
      minisoc_pkg::OPCODE_STORE:
        imm = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
      minisoc_pkg::OPCODE_BRANCH:
        imm = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
               if_instr_i[30:25], if_instr_i[11:8], 1'b0};
      minisoc_pkg::OPCODE_JAL:
        imm = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
               if_instr_i[20], if_instr_i[30:21], 1'b0};
      default:
        imm = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_valid_o <= 1'b0;
    end else begin
      id_valid_o <= if_valid_i && !flush_i;
    end
  end

  always_ff @(posedge clk) begin
    id_pc_o      <= if_pc_i;
    id_opcode_o  <= opcode;
    id_funct3_o  <= if_instr_i[14:12];
    id_rd_o      <= if_instr_i[11:7];
    id_rs1_val_o <= rs1_val_i;
    id_rs2_val_o <= rs2_val_i;
    id_imm_o     <= imm;
  end

endmodule

// ==== hw/reg_file.sv ====
// Integer register file, 32 x 32 bits
// x0 reads as zero, a write in the same cycle is seen by both read ports
`timescale 1ns/100ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  minisoc_pkg::reg_idx_t rs1_idx_i,
  input  minisoc_pkg::reg_idx_t rs2_idx_i,
  output minisoc_pkg::word_t    rs1_val_o,
  output minisoc_pkg::word_t    rs2_val_o,
  input  logic                  we_i,
  input  minisoc_pkg::reg_idx_t wr_idx_i,
  input  minisoc_pkg::word_t    wr_data_i
);

  minisoc_pkg::word_t regs [1:31];

  function automatic minisoc_pkg::word_t read_port(minisoc_pkg::reg_idx_t idx);
    if (idx == '0) return '0;
    if (we_i && (wr_idx_i == idx)) return wr_data_i;
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wr_idx_i != '0)) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  always_comb begin
    rs1_val_o = read_port(rs1_idx_i);
    rs2_val_o = read_port(rs2_idx_i);
  end

endmodule

// ==== hw/execute_stage.sv ====
// Execute and write-back stage
// One adder serves ADD/ADDI, load/store addresses and the JALR target.
// Taken branches and jumps redirect fetch combinationally
`timescale 1ns/100ps

module execute_stage (
  input  logic                  id_valid_i,
  input  minisoc_pkg::addr_t    id_pc_i,
  input  logic [6:0]            id_opcode_i,
  input  logic [2:0]            id_funct3_i,
  input  minisoc_pkg::reg_idx_t id_rd_i,
  input  minisoc_pkg::word_t    id_rs1_val_i,
  input  minisoc_pkg::word_t    id_rs2_val_i,
  input  minisoc_pkg::word_t    id_imm_i,
  output logic                  redirect_o,
  output minisoc_pkg::addr_t    redirect_pc_o,
  output logic                  rf_we_o,
  output minisoc_pkg::reg_idx_t rf_idx_o,
  output minisoc_pkg::word_t    rf_data_o,
  output minisoc_pkg::addr_t    dmem_addr_o,
  input  minisoc_pkg::word_t    dmem_rdata_i,
  output logic                  dmem_we_o,
  output minisoc_pkg::word_t    dmem_wdata_o,
  output logic                  wb_valid_o,
  output minisoc_pkg::addr_t    wb_pc_o,
  output minisoc_pkg::reg_idx_t wb_rd_o,
  output minisoc_pkg::word_t    wb_data_o,
  output logic                  store_valid_o,
  output minisoc_pkg::addr_t    store_addr_o,
  output minisoc_pkg::word_t    store_data_o
);

  logic               is_comp, is_compimm, is_load, is_store;
  logic               is_branch, is_jal, is_jalr;
  logic               br_taken;
  minisoc_pkg::word_t op_b;
  minisoc_pkg::word_t sum;

  assign is_comp    = (id_opcode_i == minisoc_pkg::OPCODE_COMP);
  assign is_compimm = (id_opcode_i == minisoc_pkg::OPCODE_COMPIMM);
  assign is_load    = (id_opcode_i == minisoc_pkg::OPCODE_LOAD);
  assign is_store   = (id_opcode_i == minisoc_pkg::OPCODE_STORE);
  assign is_branch  = (id_opcode_i == minisoc_pkg::OPCODE_BRANCH);
  assign is_jal     = (id_opcode_i == minisoc_pkg::OPCODE_JAL);
  assign is_jalr    = (id_opcode_i == minisoc_pkg::OPCODE_JALR);

  assign op_b = is_comp ? id_rs2_val_i : id_imm_i;
  assign sum  = id_rs1_val_i + op_b;

  always_comb begin
    case (id_funct3_i)
      minisoc_pkg::F3_BEQ: br_taken = (id_rs1_val_i == id_rs2_val_i);
      minisoc_pkg::F3_BNE: br_taken = (id_rs1_val_i != id_rs2_val_i);
      minisoc_pkg::F3_BLT: br_taken = ($signed(id_rs1_val_i) < $signed(id_rs2_val_i));
      minisoc_pkg::F3_BGE: br_taken = ($signed(id_rs1_val_i) >= $signed(id_rs2_val_i));
      default:             br_taken = 1'b0;
    endcase
  end

  assign redirect_o    = id_valid_i && ((is_branch && br_taken) || is_jal || is_jalr);
  assign redirect_pc_o = is_jalr ? {sum[31:1], 1'b0} : id_pc_i + id_imm_i;

  // Write back, never to x0
  assign rf_we_o  = id_valid_i && (id_rd_i != '0) &&
                    (is_comp || is_compimm || is_load || is_jal || is_jalr);
  assign rf_idx_o = id_rd_i;

  always_comb begin
    if (is_load) begin
      rf_data_o = dmem_rdata_i;
    end else if (is_jal || is_jalr) begin
      rf_data_o = id_pc_i + 32'd4;
    end else begin
      rf_data_o = sum;
    end
  end

  assign dmem_addr_o  = sum;
  assign dmem_we_o    = id_valid_i && is_store;
  assign dmem_wdata_o = id_rs2_val_i;

  // Observation ports
  assign wb_valid_o    = rf_we_o;
  assign wb_pc_o       = id_pc_i;
  assign wb_rd_o       = id_rd_i;
  assign wb_data_o     = rf_data_o;
  assign store_valid_o = dmem_we_o;
  assign store_addr_o  = sum;
  assign store_data_o  = id_rs2_val_i;

endmodule

// ==== hw/data_mem.sv ====
// Data memory model
// Combinational read, write at the clock edge, word addressed from
// DMEM_START_ADDR. Reset reloads the initial array
`timescale 1ns/100ps

module data_mem (
  input  logic               clk,
  input  logic               rst_n_i,
  input  minisoc_pkg::addr_t addr_i,
  output minisoc_pkg::word_t rdata_o,
  input  logic               we_i,
  input  minisoc_pkg::word_t wdata_i
);

  minisoc_pkg::word_t                          mem [minisoc_pkg::DMEM_WORDS];
  minisoc_pkg::addr_t                          offset;
  logic                                        in_range;
  logic [$clog2(minisoc_pkg::DMEM_WORDS)-1:0] idx;

  // Addresses below the base wrap to a large offset and fall out of range
  assign offset   = addr_i - minisoc_pkg::DMEM_START_ADDR;
  assign in_range = (offset < minisoc_pkg::DMEM_WORDS * 4);
  assign idx      = offset[$clog2(minisoc_pkg::DMEM_WORDS)+1:2];

  assign rdata_o = in_range ? mem[idx] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mem <= minisoc_pkg::DMEM_INIT;
    end else if (we_i && in_range) begin
      mem[idx] <= wdata_i;
    end
  end

endmodule

// ==== hw/minisoc_core.sv ====
// Mini SoC core top level
// Three-stage RV32I pipeline with its instruction and data memories,
// retire and store activity brought out for observation
`timescale 1ns/100ps

module minisoc_core #(
  parameter int PROG_SEL = 1
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  output logic                  wb_valid_o,
  output minisoc_pkg::addr_t    wb_pc_o,
  output minisoc_pkg::reg_idx_t wb_rd_o,
  output minisoc_pkg::word_t    wb_data_o,
  output logic                  store_valid_o,
  output minisoc_pkg::addr_t    store_addr_o,
  output minisoc_pkg::word_t    store_data_o
);

  logic                  instr_req, instr_gnt, instr_rvalid;
  minisoc_pkg::addr_t    instr_addr;
  minisoc_pkg::word_t    instr_rdata;
  logic                  redirect;
  minisoc_pkg::addr_t    redirect_pc;
  logic                  if_valid;
  minisoc_pkg::addr_t    if_pc;
  minisoc_pkg::word_t    if_instr;
  minisoc_pkg::reg_idx_t rs1_idx, rs2_idx;
  minisoc_pkg::word_t    rs1_val, rs2_val;
  logic                  id_valid;
  minisoc_pkg::addr_t    id_pc;
  logic [6:0]            id_opcode;
  logic [2:0]            id_funct3;
  minisoc_pkg::reg_idx_t id_rd;
  minisoc_pkg::word_t    id_rs1_val, id_rs2_val, id_imm;
  logic                  rf_we;
  minisoc_pkg::reg_idx_t rf_idx;
  minisoc_pkg::word_t    rf_data;
  minisoc_pkg::addr_t    dmem_addr;
  minisoc_pkg::word_t    dmem_rdata, dmem_wdata;
  logic                  dmem_we;

  ////////////////////////////////////////////////////////////////////////////
  // Front end
  ////////////////////////////////////////////////////////////////////////////

  fetch_stage u_fetch (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .if_valid_o     (if_valid),
    .if_pc_o        (if_pc),
    .if_instr_o     (if_instr)
  );

  instr_mem #(
    .PROG_SEL (PROG_SEL)
  ) u_instr_mem (
    .clk            (clk),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata)
  );

  decode_stage u_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .if_valid_i   (if_valid),
    .if_pc_i      (if_pc),
    .if_instr_i   (if_instr),
    .flush_i      (redirect),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .rs1_val_i    (rs1_val),
    .rs2_val_i    (rs2_val),
    .id_valid_o   (id_valid),
    .id_pc_o      (id_pc),
    .id_opcode_o  (id_opcode),
    .id_funct3_o  (id_funct3),
    .id_rd_o      (id_rd),
    .id_rs1_val_o (id_rs1_val),
    .id_rs2_val_o (id_rs2_val),
    .id_imm_o     (id_imm)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rs1_idx_i (rs1_idx),
    .rs2_idx_i (rs2_idx),
    .rs1_val_o (rs1_val),
    .rs2_val_o (rs2_val),
    .we_i      (rf_we),
    .wr_idx_i  (rf_idx),
    .wr_data_i (rf_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Back end
  ////////////////////////////////////////////////////////////////////////////

  execute_stage u_execute (
    .id_valid_i    (id_valid),
    .id_pc_i       (id_pc),
    .id_opcode_i   (id_opcode),
    .id_funct3_i   (id_funct3),
    .id_rd_i       (id_rd),
    .id_rs1_val_i  (id_rs1_val),
    .id_rs2_val_i  (id_rs2_val),
    .id_imm_i      (id_imm),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .rf_we_o       (rf_we),
    .rf_idx_o      (rf_idx),
    .rf_data_o     (rf_data),
    .dmem_addr_o   (dmem_addr),
    .dmem_rdata_i  (dmem_rdata),
    .dmem_we_o     (dmem_we),
    .dmem_wdata_o  (dmem_wdata),
    .wb_valid_o    (wb_valid_o),
    .wb_pc_o       (wb_pc_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .store_valid_o (store_valid_o),
    .store_addr_o  (store_addr_o),
    .store_data_o  (store_data_o)
  );

  data_mem u_data_mem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .addr_i  (dmem_addr),
    .rdata_o (dmem_rdata),
    .we_i    (dmem_we),
    .wdata_i (dmem_wdata)
  );

endmodule

// ==== dv/minisoc_chk.sv ====
// Mini SoC core protocol checker
// Bound into the core top level. Watches the instruction memory handshake,
// the quiet cycles after reset and the wrong-path window after a redirect
`timescale 1ns/100ps

module minisoc_chk (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  instr_req_i,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic                  redirect_i,
  input  minisoc_pkg::addr_t    redirect_pc_i,
  input  logic                  wb_valid_i,
  input  minisoc_pkg::addr_t    wb_pc_i,
  input  minisoc_pkg::reg_idx_t wb_rd_i,
  input  logic                  store_valid_i
);

  // Failure counts, read by the testbench at the end of the run
  int gnt_fails     = 0;
  int rvalid_fails  = 0;
  int quiet_fails   = 0;
  int x0_fails      = 0;
  int redirect_fails = 0;
  int fail_total;

  logic [2:0]         post_rst_cnt;
  logic               req_d;
  logic               redir_d1;
  logic               redir_d2;
  minisoc_pkg::addr_t target_d1;
  minisoc_pkg::addr_t target_d2;

  assign fail_total = gnt_fails + rvalid_fails + quiet_fails + x0_fails + redirect_fails;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      post_rst_cnt <= '0;
      redir_d1     <= 1'b0;
      redir_d2     <= 1'b0;
    end else begin
      if (post_rst_cnt != 3'd7) begin
        post_rst_cnt <= post_rst_cnt + 3'd1;
      end
      redir_d1 <= redirect_i;
      redir_d2 <= redir_d1;
    end
  end

  always_ff @(posedge clk) begin
    req_d     <= instr_req_i;
    target_d1 <= redirect_pc_i;
    target_d2 <= target_d1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction memory handshake
  ////////////////////////////////////////////////////////////////////////////

  a_gnt_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_gnt_i == instr_req_i)
    else begin
      gnt_fails++;
      $error("Instruction grant differs from request");
    end

  a_rvalid_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_rvalid_i |-> req_d)
    else begin
      rvalid_fails++;
      $error("Instruction rvalid without a request one cycle earlier");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Retire rules
  ////////////////////////////////////////////////////////////////////////////

  // Nothing can reach execute in the first three cycles out of reset
  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
    (post_rst_cnt < 3'd3) |-> (!wb_valid_i && !store_valid_i))
    else begin
      quiet_fails++;
      $error("Retire activity before the first instruction could reach execute");
    end

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_valid_i |-> (wb_rd_i != '0))
    else begin
      x0_fails++;
      $error("Writeback reported for register x0");
    end

  // Both wrong-path slots must stay silent
  a_redirect_slot1: assert property (@(posedge clk) disable iff (!rst_n_i)
    redir_d1 |-> (!wb_valid_i || (wb_pc_i == target_d1)))
    else begin
      redirect_fails++;
      $error("Wrong-path writeback one cycle after a redirect");
    end

  a_redirect_slot2: assert property (@(posedge clk) disable iff (!rst_n_i)
    redir_d2 |-> (!wb_valid_i || (wb_pc_i == target_d2)))
    else begin
      redirect_fails++;
      $error("Wrong-path writeback two cycles after a redirect");
    end

endmodule

bind minisoc_core minisoc_chk u_chk (
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .instr_req_i    (instr_req),
  .instr_gnt_i    (instr_gnt),
  .instr_rvalid_i (instr_rvalid),
  .redirect_i     (redirect),
  .redirect_pc_i  (redirect_pc),
  .wb_valid_i     (wb_valid_o),
  .wb_pc_i        (wb_pc_o),
  .wb_rd_i        (wb_rd_o),
  .store_valid_i  (store_valid_o)
);

// ==== dv/minisoc_tb.sv ====
// Mini SoC core testbench
// Runs the program chosen by PROG_SEL and follows retired writes and
// stores on the observation ports. Program 1 is the up/down counter,
// program 2 the bubble sort checked against a shadow of the array
`timescale 1ns/100ps

module minisoc_tb #(
  parameter int PROG_SEL = 1
);

  // Two count periods with branch penalties, or one full sort
  localparam int CYCLE_LIMIT = (PROG_SEL == 1) ? 4000 : 3000;
  // Initial clear of s0, then two periods of 30 steps each
  localparam int S0_WRITES_DONE = 61;
  // Initial clear of s1, then turns at 15, 0 and 15 before the last zero
  localparam int S1_WRITES_DONE = 4;
  localparam int QUIET_CYCLES   = 20;
  localparam int ARRAY_LEN      = 8;

  logic                  clk;
  logic                  rst_n_i;
  logic                  wb_valid;
  minisoc_pkg::addr_t    wb_pc;
  minisoc_pkg::reg_idx_t wb_rd;
  minisoc_pkg::word_t    wb_data;
  logic                  store_valid;
  minisoc_pkg::addr_t    store_addr;
  minisoc_pkg::word_t    store_data;

  int err_cnt;
  int cycles;
  bit done;
  int s0_writes;
  int s1_writes;
  int t0_writes;
  int exp_s0;
  int exp_s1;
  bit count_up;
  int ra_writes;
  int quiet;
  minisoc_pkg::word_t shadow [minisoc_pkg::DMEM_WORDS];

  minisoc_core #(
    .PROG_SEL (PROG_SEL)
  ) u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .wb_valid_o    (wb_valid),
    .wb_pc_o       (wb_pc),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .store_valid_o (store_valid),
    .store_addr_o  (store_addr),
    .store_data_o  (store_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic finish_run(input bit timed_out);
    int chk_fails;
    chk_fails = u_dut.u_chk.fail_total;
    $display("Errors: %0d value, %0d assertion, %0d timeout", err_cnt, chk_fails, timed_out);
    if (!timed_out && (err_cnt == 0) && (chk_fails == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected behavior of the two programs
  ////////////////////////////////////////////////////////////////////////////

  // Counter runs 0, 1 .. 15, 14 .. 0, 1 .. and turns at both ends
  task automatic follow_counter_write();
    if (wb_rd == 5'd8) begin
      assert ($signed(wb_data) == exp_s0)
        else report_mismatch($sformatf("s0 = %0d, expected %0d", $signed(wb_data), exp_s0));
      s0_writes++;
      if (count_up && (exp_s0 == 15)) begin
        count_up = 1'b0;
      end else if (!count_up && (exp_s0 == 0)) begin
        count_up = 1'b1;
      end
      exp_s0 = count_up ? exp_s0 + 1 : exp_s0 - 1;
    end else if (wb_rd == 5'd9) begin
      assert ($signed(wb_data) == exp_s1)
        else report_mismatch($sformatf("s1 = %0d, expected %0d", $signed(wb_data), exp_s1));
      s1_writes++;
      exp_s1 = 1 - exp_s1;
    end else if (wb_rd == 5'd5) begin
      assert ((t0_writes == 0) && (wb_data == 32'd15))
        else report_mismatch($sformatf("t0 write %0d with %0d", t0_writes + 1, wb_data));
      t0_writes++;
    end else begin
      report_mismatch($sformatf("unexpected write to x%0d", wb_rd));
    end
  endtask

  task automatic follow_sort_write();
    if (wb_rd == 5'd1) begin
      assert ((wb_pc == 32'h0000_000c) && (wb_data == 32'h0000_0010))
        else report_mismatch($sformatf("ra = %h from pc %h", wb_data, wb_pc));
      ra_writes++;
    end
  endtask

  task automatic record_store();
    minisoc_pkg::addr_t lo;
    minisoc_pkg::addr_t hi;
    int                 idx;
    lo = minisoc_pkg::DMEM_START_ADDR + 32'd4;
    hi = lo + 32'(ARRAY_LEN * 4);
    idx = int'((store_addr - minisoc_pkg::DMEM_START_ADDR) >> 2);
    assert ((PROG_SEL == 2) && (store_addr >= lo) && (store_addr < hi) &&
            (store_addr[1:0] == 2'b00))
      else report_mismatch($sformatf("store to %h outside the array", store_addr));
    if ((store_addr >= lo) && (store_addr < hi)) begin
      shadow[idx] = store_data;
    end
  endtask

  // Matching a sorted copy of the start values proves order and permutation
  task automatic verify_sorted_array();
    int ref_vals [ARRAY_LEN];
    int key;
    int j;
    for (int i = 0; i < ARRAY_LEN; i++) begin
      ref_vals[i] = $signed(minisoc_pkg::DMEM_INIT[i + 1]);
    end
    for (int i = 1; i < ARRAY_LEN; i++) begin
      key = ref_vals[i];
      j = i - 1;
      while ((j >= 0) && (ref_vals[j] > key)) begin
        ref_vals[j + 1] = ref_vals[j];
        j--;
      end
      ref_vals[j + 1] = key;
    end
    for (int i = 0; i < ARRAY_LEN; i++) begin
      assert ($signed(shadow[i + 1]) == ref_vals[i])
        else report_mismatch($sformatf("array[%0d] = %0d, expected %0d", i,
                                       $signed(shadow[i + 1]), ref_vals[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n_i && !done) begin
      if (wb_valid) begin
        if (PROG_SEL == 1) begin
          follow_counter_write();
        end else begin
          follow_sort_write();
        end
      end
      if (store_valid) begin
        record_store();
      end
      // The self-loop at 0x10 retires nothing, so the core falls silent
      if (wb_valid || store_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      if (PROG_SEL == 1) begin
        done = (s0_writes >= S0_WRITES_DONE);
      end else begin
        done = (ra_writes > 0) && (quiet >= QUIET_CYCLES);
      end
    end
  end

  initial begin
    err_cnt   = 0;
    done      = 1'b0;
    s0_writes = 0;
    s1_writes = 0;
    t0_writes = 0;
    exp_s0    = 0;
    exp_s1    = 0;
    count_up  = 1'b1;
    ra_writes = 0;
    quiet     = 0;
    for (int i = 0; i < minisoc_pkg::DMEM_WORDS; i++) begin
      shadow[i] = minisoc_pkg::DMEM_INIT[i];
    end
    rst_n_i = 1'b0;
    repeat (5) @(posedge clk);
    #10 rst_n_i = 1'b1;
    wait (done);
    if (PROG_SEL == 1) begin
      assert (t0_writes == 1)
        else report_mismatch($sformatf("t0 written %0d times", t0_writes));
      assert (s1_writes == S1_WRITES_DONE)
        else report_mismatch($sformatf("s1 written %0d times, expected %0d",
                                       s1_writes, S1_WRITES_DONE));
    end else begin
      verify_sorted_array();
    end
    finish_run(1'b0);
  end

  initial begin
    cycles = 0;
    while (!done && (cycles < CYCLE_LIMIT)) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Timeout: program did not complete within %0d cycles", CYCLE_LIMIT);
      finish_run(1'b1);
    end
  end

endmodule

// ==== src.f ====
hw/minisoc_pkg.sv
hw/instr_mem.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/data_mem.sv
hw/minisoc_core.sv
dv/minisoc_chk.sv
dv/minisoc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator for both programs
status=0
for prog in 1 2; do
  rm -rf obj_dir_$prog sim_$prog.log
  verilator --binary --timing --assert -Wno-fatal --top-module minisoc_tb \
    -GPROG_SEL=$prog -f src.f --Mdir obj_dir_$prog -o sim \
    && ./obj_dir_$prog/sim +verilator+error+limit+100 > sim_$prog.log 2>&1 \
    || status=1
  cat sim_$prog.log 2>/dev/null
  grep -qx "TEST PASSED" sim_$prog.log 2>/dev/null && echo "program $prog passed" \
    || { echo "program $prog failed"; status=1; }
done
exit $status
